/* evt_streamer.f */
design/evt_streamer_pkg.sv
design/evt_streamer_ctrl.sv
design/evt_load_engine.sv
design/evt_store_engine.sv
design/tcdm_arbiter.sv
design/evt_streamer_top.sv
bench/tcdm_mem_model.sv
bench/evt_streamer_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module evt_streamer_tb -f evt_streamer.f \
  -o evt_streamer_sim > sim.log 2>&1 &&
  ./obj_dir/evt_streamer_sim >> sim.log 2>&1
grep -qx "all tests passed" sim.log && echo "simulation passed" ||
  { echo "simulation failed, see sim.log"; exit 1; }

/* bench/evt_streamer_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module evt_streamer_tb import evt_streamer_pkg::*; ();

  localparam logic [31:0] SEED         = 32'h8bd9_07da;
  localparam logic [31:0] FILL_PATTERN = 32'ha5c3_0f96;
  localparam int unsigned MEM_DEPTH    = 256;
  localparam int unsigned MEM_AW       = $clog2(MEM_DEPTH);
  // words moved by all the transfers below
  localparam int unsigned TEST_WORDS      = 10 + 20 + 11 + 6 + 12;
  localparam int unsigned WATCHDOG_CYCLES = TEST_WORDS * 4 + MEM_DEPTH + 1500;

  logic                system_clk;
  logic                system_rst_n = 1'b0;
  logic                evt          = 1'b0;
  streamer_cfg_t       cfg          = '0;
  tcdm_req_t           tcdm_req;
  tcdm_rsp_t           tcdm_rsp;
  logic                src_valid;
  evt_word_t           src_evt;
  logic                src_ready    = 1'b1;
  logic                dst_valid    = 1'b0;
  evt_word_t           dst_evt      = '0;
  logic                dst_ready;
  logic [STATUS_W-1:0] status;
  logic                irq;

  streamer_state_e     state;
  logic                exp_trig;
  int                  seed            = SEED;
  logic                random_ready    = 1'b0;
  logic                store_feed      = 1'b0;
  logic                sweep_on        = 1'b0;
  logic [MEM_AW-1:0]   sweep_addr      = '0;
  int unsigned         exp_count       = 0;
  int unsigned         src_count       = 0;
  int unsigned         dst_count       = 0;
  evt_word_t           prev_src_evt    = '0;
  logic [31:0]         st_start        = '0;
  logic [31:0]         st_step         = 32'd1;
  int unsigned         st_count        = 0;
  int unsigned         mismatch_errors = 0;
  int unsigned         other_errors    = 0;

  evt_streamer_top #(
    .MAX_OUTSTANDING (4)
  ) evt_streamer_top_inst (
    .system_clk_i  (system_clk),
    .system_rst_ni (system_rst_n),
    .evt_i         (evt),
    .cfg_i         (cfg),
    .tcdm_req_o    (tcdm_req),
    .tcdm_rsp_i    (tcdm_rsp),
    .src_valid_o   (src_valid),
    .src_evt_o     (src_evt),
    .src_ready_i   (src_ready),
    .dst_valid_i   (dst_valid),
    .dst_evt_i     (dst_evt),
    .dst_ready_o   (dst_ready),
    .status_o      (status),
    .irq_o         (irq)
  );

  tcdm_mem_model #(
    .DEPTH (MEM_DEPTH),
    .FILL  (FILL_PATTERN),
    .SEED  (SEED)
  ) mem_inst (
    .system_clk_i  (system_clk),
    .system_rst_ni (system_rst_n),
    .req_i         (tcdm_req),
    .rsp_o         (tcdm_rsp)
  );

  initial begin
    system_clk = 1'b0;
    forever #50 system_clk = ~system_clk;
  end

  assign state    = streamer_state_e'(status[3:0]);
  // external event replaces the software trigger when enabled
  assign exp_trig = cfg.ext_trigger_en ? evt : cfg.sw_trigger;

  function automatic evt_word_t store_word(input int unsigned k);
    return {16'he7e0, k[15:0]};
  endfunction

  // memory content expected at a word address
  function automatic evt_word_t exp_mem(input logic [31:0] a);
    logic [31:0] off;
    off = a - st_start;
    if (st_count != 0 && a >= st_start && off % st_step == 0 && off / st_step < st_count) begin
      return store_word(off / st_step);
    end
    return a ^ FILL_PATTERN;
  endfunction

  function automatic int unsigned word_count(input streamer_cfg_t c);
    if (!c.end_by_addr) begin
      return c.tran_size + 1;
    end
    if (c.start_addr >= c.end_addr) begin
      return 1;
    end
    return (c.end_addr - c.start_addr + c.addr_step - 1) / c.addr_step + 1;
  endfunction

  // debug pointer at the end of a transfer, next address or words moved
  function automatic logic [15:0] end_pointer();
    if (cfg.ptr_sel) begin
      return 16'(cfg.start_addr + exp_count * cfg.addr_step);
    end
    return 16'(exp_count);
  endfunction

  task automatic note_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    mismatch_errors++;
    $display("Mismatch %s: got %h expected %h", name, got, exp);
  endtask

  task automatic count_failure(input string what);
    other_errors++;
    $display("%s", what);
  endtask

  always @(negedge system_clk) begin
    src_ready <= random_ready ? (($random(seed) & 1) != 0) : 1'b1;
    dst_valid <= store_feed && (($random(seed) & 3) != 0);
    dst_evt   <= store_word(dst_count);
  end

  // stream word counters, cleared in the init state of each transfer
  always @(posedge system_clk) begin
    prev_src_evt <= src_evt;
    if (state == LOAD || state == STORE) begin
      src_count <= 0;
      dst_count <= 0;
    end else begin
      if (src_valid && src_ready) src_count <= src_count + 1;
      if (dst_valid && dst_ready) dst_count <= dst_count + 1;
    end
  end

  a_reset_outputs: assert property (@(posedge system_clk)
    !system_rst_n |-> !tcdm_req.req && !src_valid && !dst_ready && !irq)
    else count_failure("an output was high during reset");

  a_stay_reset: assert property (@(posedge system_clk) disable iff (!system_rst_n)
    $past(!cfg.armed && state == RESET) |-> state == RESET)
    else count_failure("left RESET before being armed");

  a_src_word: assert property (@(posedge system_clk) disable iff (!system_rst_n)
    (src_valid && src_ready) |-> src_evt == exp_mem(cfg.start_addr + src_count * cfg.addr_step))
    else note_mismatch("src_evt_o", src_evt,
                       exp_mem(cfg.start_addr + src_count * cfg.addr_step));

  a_src_extra: assert property (@(posedge system_clk) disable iff (!system_rst_n)
    (src_valid && src_ready) |-> src_count < exp_count)
    else count_failure("source stream delivered more words than the transfer holds");

  a_src_hold: assert property (@(posedge system_clk) disable iff (!system_rst_n)
    $past(src_valid && !src_ready) |-> src_valid && src_evt == prev_src_evt)
    else note_mismatch("src_evt_o", src_evt, prev_src_evt);

  a_load_count: assert property (@(posedge system_clk) disable iff (!system_rst_n)
    (state == TRANSFER_END && cfg.op_load) |-> src_count == exp_count)
    else note_mismatch("src_count", src_count, exp_count);

  a_store_addr: assert property (@(posedge system_clk) disable iff (!system_rst_n)
    (dst_valid && dst_ready) |->
      tcdm_req.we && tcdm_req.addr == cfg.start_addr + dst_count * cfg.addr_step)
    else note_mismatch("tcdm_req_o.addr", tcdm_req.addr,
                       cfg.start_addr + dst_count * cfg.addr_step);

  a_store_data: assert property (@(posedge system_clk) disable iff (!system_rst_n)
    (dst_valid && dst_ready) |-> tcdm_req.wdata == store_word(dst_count))
    else note_mismatch("tcdm_req_o.wdata", tcdm_req.wdata, store_word(dst_count));

  a_store_count: assert property (@(posedge system_clk) disable iff (!system_rst_n)
    (state == TRANSFER_END && !cfg.op_load) |-> dst_count == exp_count)
    else note_mismatch("dst_count", dst_count, exp_count);

  a_idle_hold: assert property (@(posedge system_clk) disable iff (!system_rst_n)
    $past(state == IDLE && !exp_trig) |-> state == IDLE)
    else count_failure("left IDLE without a trigger");

  a_end_exit: assert property (@(posedge system_clk) disable iff (!system_rst_n)
    $past(state == TRANSFER_END) |-> state == ($past(exp_trig) ? TRANSFER_END : IDLE))
    else note_mismatch("status_o state", 32'(state), 32'($past(exp_trig) ? 7 : 1));

  a_end_status: assert property (@(posedge system_clk) disable iff (!system_rst_n)
    state == TRANSFER_END |-> status[4] && status[15:5] == '0)
    else note_mismatch("status_o[15:0]", 32'(status[15:0]), 32'h17);

  a_end_pointer: assert property (@(posedge system_clk) disable iff (!system_rst_n)
    state == TRANSFER_END |-> status[31:16] == end_pointer())
    else note_mismatch("status_o[31:16]", 32'(status[31:16]), 32'(end_pointer()));

  a_irq: assert property (@(posedge system_clk) disable iff (!system_rst_n)
    irq == $past(cfg.irq_en && cfg.irq_compare == status[3:0]))
    else note_mismatch("irq_o", 32'(irq), 32'(!irq));

  a_mem_contents: assert property (@(posedge system_clk) disable iff (!system_rst_n)
    sweep_on |-> mem_inst.mem[sweep_addr] == exp_mem(32'(sweep_addr)))
    else note_mismatch("memory word", mem_inst.mem[sweep_addr], exp_mem(32'(sweep_addr)));

  task automatic wait_state(input streamer_state_e target, input int unsigned max_cycles);
    int unsigned n;
    n = 0;
    while (state != target && n < max_cycles) begin
      @(negedge system_clk);
      n++;
    end
    if (state != target) begin
      count_failure($sformatf("timed out waiting for state %s", target.name()));
    end
  endtask

  task automatic expect_irq(input int unsigned max_cycles);
    int unsigned n;
    n = 0;
    while (!irq && n < max_cycles) begin
      @(negedge system_clk);
      n++;
    end
    if (!irq) begin
      count_failure("interrupt did not rise at the end of the transfer");
    end
  endtask

  // limit is tran_size in size mode and end_addr in address mode
  task automatic run_transfer(input logic load, input logic [31:0] start,
                              input logic [31:0] step, input logic [31:0] limit,
                              input logic by_addr);
    @(negedge system_clk);
    cfg.op_load     = load;
    cfg.start_addr  = start;
    cfg.addr_step   = step;
    cfg.end_by_addr = by_addr;
    cfg.end_addr    = limit;
    cfg.tran_size   = limit;
    exp_count       = word_count(cfg);
    if (cfg.ext_trigger_en) begin
      evt = 1'b1;
      @(negedge system_clk);
      evt = 1'b0;
    end else begin
      cfg.sw_trigger = 1'b1;
    end
    wait_state(TRANSFER_END, 40 * exp_count + 20);
    if (cfg.irq_en) begin
      expect_irq(4);
    end
    if (!cfg.ext_trigger_en) begin
      cfg.sw_trigger = 1'b0;
    end
    wait_state(IDLE, 4);
  endtask

  task automatic sweep_memory();
    for (int a = 0; a < MEM_DEPTH; a++) begin
      @(negedge system_clk);
      sweep_on   = 1'b1;
      sweep_addr = MEM_AW'(a);
    end
    @(negedge system_clk);
    sweep_on = 1'b0;
  endtask

  initial begin
    repeat (8) @(negedge system_clk);
    system_rst_n = 1'b1;
    repeat (3) @(negedge system_clk);
    cfg.armed = 1'b1;
    wait_state(IDLE, 4);
    // size-mode load with the stream always ready
    run_transfer(1'b1, 32'd8, 32'd1, 32'd9, 1'b0);
    // stalling stream exercises the pause buffer
    random_ready = 1'b1;
    run_transfer(1'b1, 32'd40, 32'd2, 32'd19, 1'b0);
    random_ready = 1'b0;
    // end-address load, interrupt on the TRANSFER_END code, address as debug pointer
    cfg.irq_en      = 1'b1;
    cfg.irq_compare = TRANSFER_END;
    cfg.ptr_sel     = 1'b1;
    run_transfer(1'b1, 32'd100, 32'd3, 32'd130, 1'b1);
    cfg.irq_en  = 1'b0;
    cfg.ptr_sel = 1'b0;
    // event trigger while the software trigger sits high
    cfg.ext_trigger_en = 1'b1;
    cfg.sw_trigger     = 1'b1;
    repeat (5) @(negedge system_clk);
    run_transfer(1'b1, 32'd200, 32'd5, 32'd5, 1'b0);
    cfg.sw_trigger     = 1'b0;
    cfg.ext_trigger_en = 1'b0;
    // store, then compare the whole memory
    st_start   = 32'd150;
    st_step    = 32'd2;
    st_count   = 12;
    store_feed = 1'b1;
    run_transfer(1'b0, st_start, st_step, 32'd11, 1'b0);
    store_feed = 1'b0;
    sweep_memory();
    repeat (2) @(negedge system_clk);
    $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge system_clk);
    $display("watchdog expired before the tests finished");
    $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/tcdm_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module tcdm_mem_model import evt_streamer_pkg::*; #(
  parameter int unsigned DEPTH = 256,
  parameter logic [31:0] FILL  = 32'ha5c3_0f96,
  parameter logic [31:0] SEED  = 32'h8bd9_07da
) (
  input  logic      system_clk_i,
  input  logic      system_rst_ni,
  input  tcdm_req_t req_i,
  output tcdm_rsp_t rsp_o
);

  localparam int unsigned AW = $clog2(DEPTH);

  evt_word_t       mem [DEPTH];
  logic [AW-1:0]   idx;
  logic            gnt_en;
  logic            r_valid_q;
  evt_word_t       rdata_q;
  int              seed;

  // every word starts as its own address xor the fill pattern
  initial begin
    seed   = SEED;
    gnt_en = 1'b0;
    for (int a = 0; a < DEPTH; a++) begin
      mem[AW'(a)] = 32'(a) ^ FILL;
    end
  end

  // grant comes on about three cycles in four
  always @(negedge system_clk_i) begin
    gnt_en <= ($random(seed) & 3) != 0;
  end

  assign idx = req_i.addr[AW-1:0];

  always_comb begin
    rsp_o.gnt     = req_i.req && gnt_en;
    rsp_o.r_valid = r_valid_q;
    rsp_o.rdata   = rdata_q;
  end

  // read data one cycle after the grant
  always_ff @(posedge system_clk_i or negedge system_rst_ni) begin
    if (!system_rst_ni) begin
      r_valid_q <= 1'b0;
      rdata_q   <= '0;
    end else begin
      r_valid_q <= rsp_o.gnt && !req_i.we;
      if (rsp_o.gnt && !req_i.we) begin
        rdata_q <= mem[idx];
      end
    end
  end

  always @(posedge system_clk_i) begin
    if (rsp_o.gnt && req_i.we) begin
      mem[idx] <= req_i.wdata;
    end
  end

endmodule

`default_nettype wire

/* design/evt_streamer_top.sv */
`timescale 1ns/1ns
`default_nettype none

module evt_streamer_top import evt_streamer_pkg::*; #(
  parameter int unsigned MAX_OUTSTANDING = 4
) (
  input  logic                system_clk_i,
  input  logic                system_rst_ni,
  input  logic                evt_i,
  input  streamer_cfg_t       cfg_i,
  output tcdm_req_t           tcdm_req_o,
  input  tcdm_rsp_t           tcdm_rsp_i,
  output logic                src_valid_o,
  output evt_word_t           src_evt_o,
  input  logic                src_ready_i,
  input  logic                dst_valid_i,
  input  evt_word_t           dst_evt_i,
  output logic                dst_ready_o,
  output logic [STATUS_W-1:0] status_o,
  output logic                irq_o
);

  logic        load_active;
  logic        store_active;
  logic [31:0] addr;
  logic        load_step;
  logic        store_step;
  logic        reads_idle;
  tcdm_req_t   load_req;
  tcdm_req_t   store_req;
  logic        load_gnt;
  logic        store_gnt;
  tcdm_rsp_t   load_rsp;

  evt_streamer_ctrl ctrl_inst (
    .system_clk_i   (system_clk_i),
    .system_rst_ni  (system_rst_ni),
    .evt_i          (evt_i),
    .cfg_i          (cfg_i),
    .load_step_i    (load_step),
    .store_step_i   (store_step),
    .reads_idle_i   (reads_idle),
    .load_active_o  (load_active),
    .store_active_o (store_active),
    .addr_o         (addr),
    .status_o       (status_o),
    .irq_o          (irq_o)
  );

  evt_load_engine #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) load_inst (
    .system_clk_i  (system_clk_i),
    .system_rst_ni (system_rst_ni),
    .active_i      (load_active),
    .addr_i        (addr),
    .req_o         (load_req),
    .gnt_i         (load_gnt),
    .rsp_i         (load_rsp),
    .step_o        (load_step),
    .reads_idle_o  (reads_idle),
    .src_valid_o   (src_valid_o),
    .src_evt_o     (src_evt_o),
    .src_ready_i   (src_ready_i)
  );

  evt_store_engine store_inst (
    .system_clk_i  (system_clk_i),
    .system_rst_ni (system_rst_ni),
    .active_i      (store_active),
    .addr_i        (addr),
    .req_o         (store_req),
    .gnt_i         (store_gnt),
    .step_o        (store_step),
    .dst_valid_i   (dst_valid_i),
    .dst_evt_i     (dst_evt_i),
    .dst_ready_o   (dst_ready_o)
  );

  tcdm_arbiter #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) arbiter_inst (
    .system_clk_i  (system_clk_i),
    .system_rst_ni (system_rst_ni),
    .load_req_i    (load_req),
    .store_req_i   (store_req),
    .load_gnt_o    (load_gnt),
    .store_gnt_o   (store_gnt),
    .load_rsp_o    (load_rsp),
    .mem_req_o     (tcdm_req_o),
    .mem_rsp_i     (tcdm_rsp_i)
  );

endmodule

`default_nettype wire

/* design/tcdm_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module tcdm_arbiter import evt_streamer_pkg::*; #(
  parameter int unsigned MAX_OUTSTANDING = 4
) (
  input  logic      system_clk_i,
  input  logic      system_rst_ni,
  input  tcdm_req_t load_req_i,
  input  tcdm_req_t store_req_i,
  output logic      load_gnt_o,
  output logic      store_gnt_o,
  output tcdm_rsp_t load_rsp_o,
  output tcdm_req_t mem_req_o,
  input  tcdm_rsp_t mem_rsp_i
);

  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic             last_store_q;
  logic             sel_store;
  logic             mem_fire;
  logic [CNT_W-1:0] pending_q;

  // on contention the engine that did not win last time goes first
  assign sel_store   = store_req_i.req && (!load_req_i.req || !last_store_q);
  assign mem_req_o   = sel_store ? store_req_i : load_req_i;
  assign mem_fire    = mem_req_o.req && mem_rsp_i.gnt;
  assign load_gnt_o  = load_req_i.req && !sel_store && mem_rsp_i.gnt;
  assign store_gnt_o = sel_store && mem_rsp_i.gnt;

  always_ff @(posedge system_clk_i or negedge system_rst_ni) begin
    if (!system_rst_ni) begin
      last_store_q <= 1'b0;
    end else if (mem_fire) begin
      last_store_q <= sel_store;
    end
  end

  // reads in flight, all of them belong to the load engine
  always_ff @(posedge system_clk_i or negedge system_rst_ni) begin
    if (!system_rst_ni) begin
      pending_q <= '0;
    end else if (mem_fire && !mem_req_o.we && !mem_rsp_i.r_valid) begin
      pending_q <= pending_q + 1'b1;
    end else if (!(mem_fire && !mem_req_o.we) && mem_rsp_i.r_valid) begin
      pending_q <= pending_q - 1'b1;
    end
  end

  always_comb begin
    load_rsp_o.gnt     = load_gnt_o;
    load_rsp_o.r_valid = mem_rsp_i.r_valid && (pending_q != '0);
    load_rsp_o.rdata   = mem_rsp_i.rdata;
  end

  a_rvalid_has_owner: assert property (@(posedge system_clk_i) disable iff (!system_rst_ni)
    mem_rsp_i.r_valid |-> pending_q != '0);

endmodule

`default_nettype wire

/* design/evt_store_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module evt_store_engine import evt_streamer_pkg::*; (
  input  logic        system_clk_i,
  input  logic        system_rst_ni,
  input  logic        active_i,
  input  logic [31:0] addr_i,
  output tcdm_req_t   req_o,
  input  logic        gnt_i,
  output logic        step_o,
  input  logic        dst_valid_i,
  input  evt_word_t   dst_evt_i,
  output logic        dst_ready_o
);

  logic write_req;

  assign write_req = active_i && dst_valid_i;

  always_comb begin
    req_o.req   = write_req;
    req_o.we    = 1'b1;
    req_o.addr  = addr_i;
    req_o.wdata = dst_evt_i;
  end

  // stream word is taken when memory accepts the write
  assign dst_ready_o = write_req && gnt_i;
  assign step_o      = dst_ready_o;

  // a grant only answers a write that was asked for
  a_gnt_has_req: assert property (@(posedge system_clk_i) disable iff (!system_rst_ni)
    gnt_i |-> write_req);

endmodule

`default_nettype wire

/* design/evt_load_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module evt_load_engine import evt_streamer_pkg::*; #(
  parameter int unsigned MAX_OUTSTANDING = 4
) (
  input  logic        system_clk_i,
  input  logic        system_rst_ni,
  input  logic        active_i,
  input  logic [31:0] addr_i,
  output tcdm_req_t   req_o,
  input  logic        gnt_i,
  input  tcdm_rsp_t   rsp_i,
  output logic        step_o,
  output logic        reads_idle_o,
  output logic        src_valid_o,
  output evt_word_t   src_evt_o,
  input  logic        src_ready_i
);

  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [CNT_W-1:0] outstanding_q;
  logic             pause_valid_q;
  evt_word_t        pause_q;
  logic             can_issue;

  // no new read while the stream stalls or a paused word waits
  assign can_issue = active_i && src_ready_i && !pause_valid_q &&
                     (outstanding_q < CNT_W'(MAX_OUTSTANDING));

  always_comb begin
    req_o.req   = can_issue;
    req_o.we    = 1'b0;
    req_o.addr  = addr_i;
    req_o.wdata = '0;
  end

  assign step_o = can_issue && gnt_i;

  always_ff @(posedge system_clk_i or negedge system_rst_ni) begin
    if (!system_rst_ni) begin
      outstanding_q <= '0;
    end else if (step_o && !rsp_i.r_valid) begin
      outstanding_q <= outstanding_q + 1'b1;
    end else if (!step_o && rsp_i.r_valid) begin
      outstanding_q <= outstanding_q - 1'b1;
    end
  end

  // returning word parked while the stream is stalled
  always_ff @(posedge system_clk_i or negedge system_rst_ni) begin
    if (!system_rst_ni) begin
      pause_valid_q <= 1'b0;
    end else if (rsp_i.r_valid && !src_ready_i) begin
      pause_valid_q <= 1'b1;
    end else if (pause_valid_q && src_ready_i) begin
      pause_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge system_clk_i) begin
    if (rsp_i.r_valid && !src_ready_i) begin
      pause_q <= rsp_i.rdata;
    end
  end

  assign src_valid_o  = pause_valid_q || rsp_i.r_valid;
  assign src_evt_o    = pause_valid_q ? pause_q : rsp_i.rdata;
  assign reads_idle_o = (outstanding_q == '0) && !pause_valid_q;

  a_outstanding_bound: assert property (@(posedge system_clk_i) disable iff (!system_rst_ni)
    outstanding_q <= CNT_W'(MAX_OUTSTANDING));

  // a read return on top of a parked word would be dropped
  a_no_return_while_paused: assert property (@(posedge system_clk_i)
    disable iff (!system_rst_ni) pause_valid_q |-> !rsp_i.r_valid);

endmodule

`default_nettype wire

/* design/evt_streamer_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module evt_streamer_ctrl import evt_streamer_pkg::*; (
  input  logic                system_clk_i,
  input  logic                system_rst_ni,
  input  logic                evt_i,
  input  streamer_cfg_t       cfg_i,
  input  logic                load_step_i,
  input  logic                store_step_i,
  input  logic                reads_idle_i,
  output logic                load_active_o,
  output logic                store_active_o,
  output logic [31:0]         addr_o,
  output logic [STATUS_W-1:0] status_o,
  output logic                irq_o
);

  streamer_state_e state_q, state_d;
  logic        trigger;
  logic        addr_init;
  logic        step;
  logic [31:0] addr_q;
  logic [31:0] tran_cnt_q;
  logic        addr_done_q;
  logic        transfer_end;
  logic [15:0] trans_ptr;

  // external event overrides the software trigger when enabled
  assign trigger = cfg_i.ext_trigger_en ? evt_i : cfg_i.sw_trigger;

  always_ff @(posedge system_clk_i or negedge system_rst_ni) begin
    if (!system_rst_ni) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      RESET: begin
        if (cfg_i.armed) begin
          state_d = IDLE;
        end
      end
      IDLE: begin
        if (trigger) begin
          state_d = cfg_i.op_load ? LOAD : STORE;
        end
      end
      LOAD: begin
        state_d = STREAM_IN;
      end
      STREAM_IN: begin
        if (transfer_end) begin
          state_d = reads_idle_i ? TRANSFER_END : STREAM_PAUSE;
        end
      end
      // tail of a load, reads in flight and the pause buffer drain here
      STREAM_PAUSE: begin
        if (reads_idle_i) begin
          state_d = TRANSFER_END;
        end
      end
      STORE: begin
        state_d = STREAM_OUT;
      end
      STREAM_OUT: begin
        if (transfer_end) begin
          state_d = TRANSFER_END;
        end
      end
      TRANSFER_END: begin
        if (!trigger) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign addr_init      = (state_q == LOAD) || (state_q == STORE);
  assign step           = load_step_i || store_step_i;
  assign load_active_o  = (state_q == STREAM_IN) && !transfer_end;
  assign store_active_o = (state_q == STREAM_OUT) && !transfer_end;
  assign addr_o         = addr_q;

  always_ff @(posedge system_clk_i or negedge system_rst_ni) begin
    if (!system_rst_ni) begin
      addr_q      <= '0;
      tran_cnt_q  <= '0;
      addr_done_q <= 1'b0;
    end else if (addr_init) begin
      addr_q      <= cfg_i.start_addr;
      tran_cnt_q  <= '0;
      addr_done_q <= 1'b0;
    end else if (step) begin
      addr_q      <= addr_q + cfg_i.addr_step;
      tran_cnt_q  <= tran_cnt_q + 32'd1;
      // the access at or past end_addr is the last one
      addr_done_q <= addr_done_q || (addr_q >= cfg_i.end_addr);
    end
  end

  assign transfer_end = cfg_i.end_by_addr ? addr_done_q : (tran_cnt_q > cfg_i.tran_size);

  // debug pointer in the upper half of the status word
  assign trans_ptr = cfg_i.ptr_sel ? addr_q[15:0] : tran_cnt_q[15:0];

  always_comb begin
    status_o        = '0;
    status_o[3:0]   = state_q;
    status_o[4]     = transfer_end;
    status_o[31:16] = trans_ptr;
  end

  always_ff @(posedge system_clk_i or negedge system_rst_ni) begin
    if (!system_rst_ni) begin
      irq_o <= 1'b0;
    end else begin
      irq_o <= cfg_i.irq_en && (cfg_i.irq_compare == status_o[3:0]);
    end
  end

  // engines only step while the FSM lets them
  a_step_only_active: assert property (@(posedge system_clk_i) disable iff (!system_rst_ni)
    (!load_step_i || load_active_o) && (!store_step_i || store_active_o));

endmodule

`default_nettype wire

/* design/evt_streamer_pkg.sv */
`default_nettype none

package evt_streamer_pkg;

  // status word width, low bits carry end flag and state code
  localparam int unsigned STATUS_W = 32;

  typedef logic [31:0] evt_word_t;

  typedef enum logic [3:0] {
    RESET        = 4'd0,
    IDLE         = 4'd1,
    LOAD         = 4'd2,
    STREAM_IN    = 4'd3,
    STREAM_PAUSE = 4'd4,
    STORE        = 4'd5,
    STREAM_OUT   = 4'd6,
    TRANSFER_END = 4'd7
  } streamer_state_e;

  typedef struct packed {
    logic        armed;
    logic        sw_trigger;
    logic        ext_trigger_en;
    // 1 = load, 0 = store
    logic        op_load;
    // 1 = end address, 0 = transaction size
    logic        end_by_addr;
    logic        ptr_sel;
    logic        irq_en;
    logic [3:0]  irq_compare;
    logic [31:0] start_addr;
    logic [31:0] addr_step;
    logic [31:0] end_addr;
    logic [31:0] tran_size;
  } streamer_cfg_t;

  // whole-word accesses only
  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    evt_word_t   wdata;
  } tcdm_req_t;

  typedef struct packed {
    logic        gnt;
    logic        r_valid;
    evt_word_t   rdata;
  } tcdm_rsp_t;

endpackage

`default_nettype wire
